// ==== hw/rv32_decode_pkg.sv ====
package rv32_decode_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    ////////////////////////////////////////////////////////////
    // Base opcodes
    ////////////////////////////////////////////////////////////

    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_auipc  = 7'b0010111;
    localparam logic [6:0] opc_jal    = 7'b1101111;
    localparam logic [6:0] opc_jalr   = 7'b1100111;
    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_load   = 7'b0000011;
    localparam logic [6:0] opc_store  = 7'b0100011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_op     = 7'b0110011;

    // ALU funct3
    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_sll     = 3'b001;
    localparam logic [2:0] f3_slt     = 3'b010;
    localparam logic [2:0] f3_sltu    = 3'b011;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_srl_sra = 3'b101;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;

    // Branch funct3
    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;
    localparam logic [2:0] f3_blt  = 3'b100;
    localparam logic [2:0] f3_bge  = 3'b101;
    localparam logic [2:0] f3_bltu = 3'b110;
    localparam logic [2:0] f3_bgeu = 3'b111;

    // Load and store funct3
    localparam logic [2:0] f3_lb  = 3'b000;
    localparam logic [2:0] f3_lh  = 3'b001;
    localparam logic [2:0] f3_lw  = 3'b010;
    localparam logic [2:0] f3_lbu = 3'b100;
    localparam logic [2:0] f3_lhu = 3'b101;
    localparam logic [2:0] f3_sb  = 3'b000;
    localparam logic [2:0] f3_sh  = 3'b001;
    localparam logic [2:0] f3_sw  = 3'b010;

    localparam logic [6:0] f7_base = 7'b0000000;
    localparam logic [6:0] f7_alt  = 7'b0100000;

    ////////////////////////////////////////////////////////////
    // Encoded control fields
    ////////////////////////////////////////////////////////////

    typedef enum logic [2:0] {
        fmt_r  = 3'd0,
        fmt_i  = 3'd1,
        fmt_s  = 3'd2,
        fmt_u  = 3'd3,
        fmt_sb = 3'd4,
        fmt_uj = 3'd5
    } imm_format_t;

    // Codes 14 and 15 are left free
    typedef enum logic [4:0] {
        alu_nop  = 5'd0,  alu_add  = 5'd1,  alu_sub  = 5'd2,  alu_sll  = 5'd3,
        alu_slt  = 5'd4,  alu_sltu = 5'd5,  alu_xor  = 5'd6,  alu_srl  = 5'd7,
        alu_sra  = 5'd8,  alu_or   = 5'd9,  alu_and  = 5'd10, alu_slli = 5'd11,
        alu_srli = 5'd12, alu_srai = 5'd13, alu_jal  = 5'd16, alu_jalr = 5'd17,
        alu_beq  = 5'd18, alu_bne  = 5'd19, alu_blt  = 5'd20, alu_bge  = 5'd21,
        alu_bltu = 5'd22, alu_bgeu = 5'd23
    } alu_op_t;

    typedef enum logic [2:0] {
        ld_none = 3'd0,
        ld_b_s  = 3'd2,
        ld_b_u  = 3'd3,
        ld_h_s  = 3'd4,
        ld_h_u  = 3'd5,
        ld_w    = 3'd6
    } load_kind_t;

    typedef enum logic [1:0] {
        st_none = 2'd0,
        st_b    = 2'd1,
        st_h    = 2'd2,
        st_w    = 2'd3
    } store_kind_t;

    typedef enum logic [3:0] {
        cls_lui, cls_auipc, cls_jal, cls_jalr, cls_branch,
        cls_load, cls_store, cls_op_imm, cls_op, cls_illegal
    } instr_class_t;

    ////////////////////////////////////////////////////////////
    // Instruction word and control word
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [6:0]            funct7;
        logic [reg_addr_w-1:0] rs2;
        logic [reg_addr_w-1:0] rs1;
        logic [2:0]            funct3;
        logic [reg_addr_w-1:0] rd;
        logic [6:0]            opcode;
    } instr_r_t;

    // Bits 24..20 carry the shift amount in immediate shifts
    typedef struct packed {
        logic [6:0]            funct7;
        logic [reg_addr_w-1:0] shamt;
        logic [reg_addr_w-1:0] rs1;
        logic [2:0]            funct3;
        logic [reg_addr_w-1:0] rd;
        logic [6:0]            opcode;
    } instr_sh_t;

    typedef union packed {
        instr_r_t  r;
        instr_sh_t sh;
    } instr_u;

    typedef struct packed {
        imm_format_t           imm_format;
        logic [reg_addr_w-1:0] rs1_addr;
        logic [reg_addr_w-1:0] rs2_addr;
        logic [reg_addr_w-1:0] rd_addr;
        logic [reg_addr_w-1:0] shift_amount;
        alu_op_t               alu_op;
        logic                  alu_in1_sel;
        logic                  alu_in2_sel;
        load_kind_t            load_kind;
        store_kind_t           store_kind;
        logic                  wb_sel;
        logic                  rd_we;
    } ctrl_t;

endpackage

// ==== hw/instr_class_decoder.sv ====
`timescale 1ns/10ps

module instr_class_decoder import rv32_decode_pkg::*; (
    input  instr_u                instr,
    output instr_class_t          cls,
    output imm_format_t           imm_format,
    output logic [reg_addr_w-1:0] rs1_addr,
    output logic [reg_addr_w-1:0] rs2_addr,
    output logic [reg_addr_w-1:0] rd_addr,
    output logic                  alu_in1_sel,
    output logic                  alu_in2_sel,
    output logic                  wb_sel,
    output logic                  rd_we
);

    // Only place in the design where the opcode is tested
    always_comb
    begin
        case (instr.r.opcode)
            opc_lui:    cls = cls_lui;
            opc_auipc:  cls = cls_auipc;
            opc_jal:    cls = cls_jal;
            opc_jalr:   cls = cls_jalr;
            opc_branch: cls = cls_branch;
            opc_load:   cls = cls_load;
            opc_store:  cls = cls_store;
            opc_op_imm: cls = cls_op_imm;
            opc_op:     cls = cls_op;
            default:    cls = cls_illegal;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Format, register fields and selects per class
    ////////////////////////////////////////////////////////////

    always_comb
    begin
        imm_format  = fmt_r;
        rs1_addr    = '0;
        rs2_addr    = '0;
        rd_addr     = '0;
        alu_in1_sel = 1'b0;
        alu_in2_sel = 1'b0;
        wb_sel      = 1'b0;
        rd_we       = 1'b0;

        // Unused register fields stay at zero
        if (cls inside {cls_jalr, cls_branch, cls_load, cls_store, cls_op_imm, cls_op})
            rs1_addr = instr.r.rs1;
        if (cls inside {cls_branch, cls_store, cls_op})
            rs2_addr = instr.r.rs2;
        if (!(cls inside {cls_branch, cls_store, cls_illegal}))
        begin
            rd_addr = instr.r.rd;
            rd_we   = 1'b1;
        end

        case (cls)
            cls_lui:
            begin
                imm_format  = fmt_u;
                alu_in2_sel = 1'b1;
            end
            cls_auipc:
            begin
                imm_format  = fmt_u;
                alu_in1_sel = 1'b1;
                alu_in2_sel = 1'b1;
            end
            cls_jal:    imm_format = fmt_uj;
            cls_jalr:   imm_format = fmt_i;
            cls_branch: imm_format = fmt_sb;
            cls_load:
            begin
                imm_format  = fmt_i;
                alu_in2_sel = 1'b1;
                wb_sel      = 1'b1;
            end
            cls_store:
            begin
                imm_format  = fmt_s;
                alu_in2_sel = 1'b1;
            end
            cls_op_imm:
            begin
                imm_format  = fmt_i;
                alu_in2_sel = 1'b1;
            end
            default:    imm_format = fmt_r;
        endcase
    end

endmodule

// ==== hw/alu_op_decoder.sv ====
`timescale 1ns/10ps

module alu_op_decoder import rv32_decode_pkg::*; (
    input  instr_class_t          cls,
    input  instr_u                instr,
    output alu_op_t               alu_op,
    output logic [reg_addr_w-1:0] shift_amount
);

    always_comb
    begin
        alu_op = alu_nop;
        case (cls)
            cls_lui, cls_auipc, cls_load, cls_store:
                alu_op = alu_add;
            cls_jal:  alu_op = alu_jal;
            cls_jalr: alu_op = alu_jalr;
            cls_branch:
            begin
                case (instr.r.funct3)
                    f3_beq:  alu_op = alu_beq;
                    f3_bne:  alu_op = alu_bne;
                    f3_blt:  alu_op = alu_blt;
                    f3_bge:  alu_op = alu_bge;
                    f3_bltu: alu_op = alu_bltu;
                    f3_bgeu: alu_op = alu_bgeu;
                    default: alu_op = alu_nop;
                endcase
            end
            cls_op:
            begin
                case (instr.r.funct3)
                    f3_add_sub:
                    begin
                        if (instr.r.funct7 == f7_base)
                            alu_op = alu_add;
                        else if (instr.r.funct7 == f7_alt)
                            alu_op = alu_sub;
                    end
                    f3_sll:  alu_op = alu_sll;
                    f3_slt:  alu_op = alu_slt;
                    f3_sltu: alu_op = alu_sltu;
                    f3_xor:  alu_op = alu_xor;
                    f3_srl_sra:
                    begin
                        if (instr.r.funct7 == f7_base)
                            alu_op = alu_srl;
                        else if (instr.r.funct7 == f7_alt)
                            alu_op = alu_sra;
                    end
                    f3_or:   alu_op = alu_or;
                    default: alu_op = alu_and;
                endcase
            end
            cls_op_imm:
            begin
                // No sub form for immediates
                case (instr.r.funct3)
                    f3_add_sub: alu_op = alu_add;
                    f3_sll:     alu_op = alu_slli;
                    f3_slt:     alu_op = alu_slt;
                    f3_sltu:    alu_op = alu_sltu;
                    f3_xor:     alu_op = alu_xor;
                    f3_srl_sra:
                    begin
                        if (instr.sh.funct7 == f7_base)
                            alu_op = alu_srli;
                        else if (instr.sh.funct7 == f7_alt)
                            alu_op = alu_srai;
                    end
                    f3_or:      alu_op = alu_or;
                    default:    alu_op = alu_and;
                endcase
            end
            default:  alu_op = alu_nop;
        endcase
    end

    // Shamt only for the immediate shifts
    assign shift_amount = (alu_op inside {alu_slli, alu_srli, alu_srai}) ?
                          instr.sh.shamt : '0;

endmodule

// ==== hw/mem_access_decoder.sv ====
`timescale 1ns/10ps

module mem_access_decoder import rv32_decode_pkg::*; (
    input  instr_class_t cls,
    input  logic [2:0]   funct3,
    output load_kind_t   load_kind,
    output store_kind_t  store_kind
);

    always_comb
    begin
        load_kind = ld_none;
        if (cls == cls_load)
        begin
            case (funct3)
                f3_lb:   load_kind = ld_b_s;
                f3_lh:   load_kind = ld_h_s;
                f3_lw:   load_kind = ld_w;
                f3_lbu:  load_kind = ld_b_u;
                f3_lhu:  load_kind = ld_h_u;
                default: load_kind = ld_none;
            endcase
        end
    end

    // Stores wider than a word do not exist in RV32
    always_comb
    begin
        store_kind = st_none;
        if (cls == cls_store)
        begin
            case (funct3)
                f3_sb:   store_kind = st_b;
                f3_sh:   store_kind = st_h;
                f3_sw:   store_kind = st_w;
                default: store_kind = st_none;
            endcase
        end
    end

endmodule

// ==== hw/ins_decoder.sv ====
`timescale 1ns/10ps

module ins_decoder import rv32_decode_pkg::*; (
    input  instr_u instr,
    output ctrl_t  ctrl
);

    instr_class_t          cls;
    imm_format_t           imm_format;
    logic [reg_addr_w-1:0] rs1_addr;
    logic [reg_addr_w-1:0] rs2_addr;
    logic [reg_addr_w-1:0] rd_addr;
    logic [reg_addr_w-1:0] shift_amount;
    alu_op_t               alu_op;
    logic                  alu_in1_sel;
    logic                  alu_in2_sel;
    load_kind_t            load_kind;
    store_kind_t           store_kind;
    logic                  wb_sel;
    logic                  rd_we;

    ////////////////////////////////////////////////////////////
    // Decoders
    ////////////////////////////////////////////////////////////

    instr_class_decoder i_instr_class_decoder (
        .instr       (instr),
        .cls         (cls),
        .imm_format  (imm_format),
        .rs1_addr    (rs1_addr),
        .rs2_addr    (rs2_addr),
        .rd_addr     (rd_addr),
        .alu_in1_sel (alu_in1_sel),
        .alu_in2_sel (alu_in2_sel),
        .wb_sel      (wb_sel),
        .rd_we       (rd_we)
    );

    alu_op_decoder i_alu_op_decoder (
        .cls          (cls),
        .instr        (instr),
        .alu_op       (alu_op),
        .shift_amount (shift_amount)
    );

    mem_access_decoder i_mem_access_decoder (
        .cls        (cls),
        .funct3     (instr.r.funct3),
        .load_kind  (load_kind),
        .store_kind (store_kind)
    );

    assign ctrl = '{
        imm_format:   imm_format,
        rs1_addr:     rs1_addr,
        rs2_addr:     rs2_addr,
        rd_addr:      rd_addr,
        shift_amount: shift_amount,
        alu_op:       alu_op,
        alu_in1_sel:  alu_in1_sel,
        alu_in2_sel:  alu_in2_sel,
        load_kind:    load_kind,
        store_kind:   store_kind,
        wb_sel:       wb_sel,
        rd_we:        rd_we
    };

endmodule

// ==== testbench/tb_ins_decoder.sv ====
`timescale 1ns/10ps

module tb_ins_decoder import rv32_decode_pkg::*; ();

    localparam int max_trace_lines      = 256;
    localparam int reset_cycles         = 5;
    localparam int reset_timeout_cycles = 50;

    logic   clk;
    logic   rst_n;
    instr_u instr;
    ctrl_t  ctrl;

    // Even entries hold instruction words, odd entries the expected control words
    logic [39:0] trace_mem [0:2*max_trace_lines-1];
    int          pair_count;

    ins_decoder i_ins_decoder (
        .instr (instr),
        .ctrl  (ctrl)
    );

    ////////////////////////////////////////////////////////////
    // Clock and reset
    ////////////////////////////////////////////////////////////

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial
    begin
        rst_n = 1'b0;
        instr = '0;
        repeat (reset_cycles) @(posedge clk);
        rst_n <= 1'b1;
    end

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic load_trace();
        int fd;
        fd = $fopen("testbench/decode_trace.txt", "r");
        if (fd == 0)
            abort_run("Trace file testbench/decode_trace.txt could not be opened");
        $fclose(fd);

        // All ones never occurs in the trace, so it marks unused entries
        for (int k = 0; k < 2 * max_trace_lines; k++)
            trace_mem[k] = '1;
        $readmemh("testbench/decode_trace.txt", trace_mem);

        pair_count = 0;
        while (pair_count < max_trace_lines && trace_mem[2*pair_count] !== '1)
        begin
            if (trace_mem[2*pair_count+1] === '1)
                abort_run($sformatf("Trace line %0d has no expected control word",
                                    pair_count));
            pair_count++;
        end
        if (pair_count == 0)
            abort_run("Trace file holds no instruction lines");
        if (pair_count == max_trace_lines)
            abort_run("Trace file has more lines than the testbench can hold");
    endtask

    task automatic wait_for_reset_release();
        int cycles;
        cycles = 0;
        while (rst_n !== 1'b1)
        begin
            @(posedge clk);
            cycles++;
            if (cycles > reset_timeout_cycles)
                abort_run("Reset was not released in time");
        end
    endtask

    task automatic check_ctrl(input int index, input logic [31:0] word, input ctrl_t expected);
        assert (ctrl === expected)
        else
        begin
            $display("[ERROR] %0d ns: line %0d instr %08h gives ctrl %010h, expected %010h",
                     $time, index, word, ctrl, expected);
            $display("Errors found");
            $fatal(1);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Stimulus and checking
    ////////////////////////////////////////////////////////////

    initial
    begin
        int gap;
        void'($urandom(43487));
        load_trace();
        wait_for_reset_release();

        for (int i = 0; i < pair_count; i++)
        begin
            gap = $urandom() % 4;
            repeat (gap) @(posedge clk);
            @(posedge clk);
            instr <= trace_mem[2*i][31:0];
            // Decoder is combinational, result settles before the falling edge
            @(negedge clk);
            check_ctrl(i, trace_mem[2*i][31:0], trace_mem[2*i+1][36:0]);
        end

        $display("No errors");
        $finish;
    end

endmodule

// ==== testbench/decode_trace.txt ====
// Columns: instruction word, expected 37-bit control word (both hex)
// Control word from MSB: imm_format rs1 rs2 rd shamt alu_op in1 in2 load store wb we
123452B7 0C00280281
00001517 0C00500381
FFDFF0EF 1400082001
010280E7 04A0082201
00730463 10C7002400
00731463 10C7002600
00734463 10C7002800
00735463 10C7002A00
00736463 10C7002C00
00737463 10C7002E00
00732463 10C7000000
00410403 04404002A3
00411403 04404002C3
00412403 04404002E3
00414403 04404002B3
00415403 04404002D3
00413403 0440400283
00918223 0869000284
00919223 0869000288
0091A223 086900028C
00D605B3 018D580201
40D605B3 018D580401
00D615B3 018D580601
00D635B3 018D580A01
00D655B3 018D580E01
40D655B3 018D581001
00D665B3 018D581201
00D675B3 018D581401
02D605B3 018D580001
12378713 05E0700281
0FF7F713 05E0701481
0057A713 05E0700881
00779713 05E071D681
01F7D713 05E077D881
4037D713 05E070DA81
2057D713 05E0700081
00000000 0000000000
FFFFFFFF 0000000000

// ==== verilog.f ====
hw/rv32_decode_pkg.sv
hw/instr_class_decoder.sv
hw/alu_op_decoder.sv
hw/mem_access_decoder.sv
hw/ins_decoder.sv
testbench/tb_ins_decoder.sv

// ==== Bender.yml ====
package:
  name: rv32_ins_decoder

sources:
  - hw/rv32_decode_pkg.sv
  - hw/instr_class_decoder.sv
  - hw/alu_op_decoder.sv
  - hw/mem_access_decoder.sv
  - hw/ins_decoder.sv
  - target: test
    files:
      - testbench/tb_ins_decoder.sv
